// File: hw/loopers_pkg.sv
////////////////////
// Shared widths, encodings and bus types for the loopers core
// Imported by every RTL module and by the testbench
////////////////////
`default_nettype none

package loopers_pkg;

   localparam int data_w    = 16;   // Data word
   localparam int addr_w    = 8;    // Word address
   localparam int mem_depth = 256;
   localparam int reg_n     = 8;

   typedef logic [2:0] reg_idx_t;

   // ALU modes, both 00x codes are add
   typedef enum logic [2:0] {
      add     = 3'b000,
      add_alt = 3'b001,
      sub     = 3'b010,   // Add plus one, real subtract needs inversion
      and_op  = 3'b011,
      or_op   = 3'b100,
      xor_op  = 3'b101,
      not_op  = 3'b110,
      sra     = 3'b111
   } alu_mode_t;

   typedef enum logic [3:0] {
      op_alu     = 4'h0,
      op_alu_inv = 4'h1,   // Same as op_alu with rt inverted
      op_ldi     = 4'h2,
      op_ld      = 4'h3,
      op_st      = 4'h4,
      op_bnz     = 4'h5,
      op_halt    = 4'hf
   } opcode_t;

   ////////////////////
   // Instruction formats
   ////////////////////
   typedef struct packed {
      opcode_t   opcode;
      reg_idx_t  rd;
      reg_idx_t  rs;
      reg_idx_t  rt;
      alu_mode_t mode;
   } r_fmt_t;

   typedef struct packed {
      opcode_t          opcode;
      reg_idx_t         rd;
      logic signed [8:0] imm;   // ldi value or bnz displacement
   } i_fmt_t;

   typedef struct packed {
      opcode_t           opcode;
      reg_idx_t          rd;
      reg_idx_t          rs;   // Base register
      logic signed [5:0] off;
   } m_fmt_t;

   typedef union packed {
      r_fmt_t r_fmt;
      i_fmt_t i_fmt;
      m_fmt_t m_fmt;
   } instr_t;

   // Memory bus, one format for all three requesters
   typedef struct packed {
      logic              req;
      logic              we;
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] wdata;
   } mem_req_t;

   typedef struct packed {
      logic              rvalid;   // One-cycle pulse
      logic [data_w-1:0] rdata;
   } mem_rsp_t;

   typedef enum logic [1:0] {
      own_host  = 2'd0,
      own_lsu   = 2'd1,
      own_fetch = 2'd2
   } owner_t;

endpackage

`default_nettype wire

// File: hw/alu.sv
////////////////////
// Combinational 16-bit ALU
// Second operand may be inverted before the mode select
////////////////////
`default_nettype none

module alu
   import loopers_pkg::*;
(
   input  logic [data_w-1:0] alu_op1,
   input  logic [data_w-1:0] alu_op2,
   input  alu_mode_t         alu_mode,
   input  logic              alu_en,
   input  logic              alu_inv_rt,
   output logic [data_w-1:0] alu_out
);

   logic [data_w-1:0] op2_x;   // op2 after optional inversion

   ////////////////////
   // Operand inverter
   ////////////////////
   assign op2_x = alu_op2 ^ {data_w{alu_inv_rt}};

   always_comb begin
      alu_out = '0;   // Disabled ALU drives zero
      if (alu_en) begin
         case (alu_mode)
            add, add_alt: alu_out = alu_op1 + op2_x;
            sub:          alu_out = alu_op1 + op2_x + 1'b1;   // With inversion gives op1 - op2
            and_op:       alu_out = alu_op1 & op2_x;
            or_op:        alu_out = alu_op1 | op2_x;
            xor_op:       alu_out = alu_op1 ^ op2_x;
            not_op:       alu_out = ~alu_op1;
            // Shift count from raw op2, sign bit fills from the left
            sra:          alu_out = $signed(alu_op1) >>> alu_op2[3:0];
            default:      alu_out = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
////////////////////
// Eight-entry register file
// Two combinational reads, one write at the clock edge
////////////////////
`default_nettype none

module reg_file
   import loopers_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  reg_idx_t          rd_a,
   input  reg_idx_t          rd_b,
   output logic [data_w-1:0] data_a,
   output logic [data_w-1:0] data_b,
   input  logic              we,
   input  reg_idx_t          wr_idx,
   input  logic [data_w-1:0] wr_data
);

   logic [data_w-1:0] regs [reg_n];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < reg_n; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[wr_idx] <= wr_data;
      end
   end

   // No bypass, a same-cycle write shows up next cycle
   assign data_a = regs[rd_a];
   assign data_b = regs[rd_b];

endmodule

`default_nettype wire

// File: hw/unified_mem.sv
////////////////////
// Single-port program and data RAM
// Registered read, data valid one cycle after the request
////////////////////
`default_nettype none

module unified_mem
   import loopers_pkg::*;
(
   input  logic              clk,
   input  mem_req_t          mem_req,
   output logic [data_w-1:0] rdata
);

   logic [data_w-1:0] mem [mem_depth];   // Contents survive reset

   always_ff @(posedge clk) begin
      if (mem_req.req) begin
         if (mem_req.we) begin
            mem[mem_req.addr] <= mem_req.wdata;
         end else begin
            rdata <= mem[mem_req.addr];   // Holds until next read
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/mem_arbiter.sv
////////////////////
// Fixed-priority memory arbiter, host over lsu over fetch
// Read data is steered back to the owner of the read
////////////////////
`default_nettype none

module mem_arbiter
   import loopers_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  mem_req_t          host_req,
   input  mem_req_t          lsu_req,
   input  mem_req_t          fetch_req,
   output logic              lsu_gnt,
   output logic              fetch_gnt,
   output mem_rsp_t          host_rsp,
   output mem_rsp_t          lsu_rsp,
   output mem_rsp_t          fetch_rsp,
   output mem_req_t          mem_req,
   input  logic [data_w-1:0] mem_rdata
);

   owner_t gnt_own;    // Winner this cycle
   owner_t rd_own;     // Owner of the read in flight
   logic   rd_pend;    // Read data arrives this cycle

   ////////////////////
   // Grant select
   ////////////////////
   always_comb begin
      mem_req   = '0;
      lsu_gnt   = 1'b0;
      fetch_gnt = 1'b0;
      gnt_own   = own_fetch;
      if (host_req.req) begin   // Host has no grant, it always wins
         mem_req = host_req;
         gnt_own = own_host;
      end else if (lsu_req.req) begin
         mem_req = lsu_req;
         lsu_gnt = 1'b1;
         gnt_own = own_lsu;
      end else if (fetch_req.req) begin
         mem_req   = fetch_req;
         fetch_gnt = 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_pend <= 1'b0;
         rd_own  <= own_host;
      end else begin
         rd_pend <= mem_req.req & ~mem_req.we;   // Writes return nothing
         rd_own  <= gnt_own;
      end
   end

   // Same data to all, rvalid only toward the owner
   assign host_rsp  = '{rvalid: rd_pend && (rd_own == own_host),  rdata: mem_rdata};
   assign lsu_rsp   = '{rvalid: rd_pend && (rd_own == own_lsu),   rdata: mem_rdata};
   assign fetch_rsp = '{rvalid: rd_pend && (rd_own == own_fetch), rdata: mem_rdata};

endmodule

`default_nettype wire

// File: hw/fetch_unit.sv
////////////////////
// Program counter and instruction fetch
// One fetch in flight, next one after retire or branch
////////////////////
`default_nettype none

module fetch_unit
   import loopers_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              run,
   input  logic              next_instr,
   input  logic              branch,
   input  logic [addr_w-1:0] branch_target,
   output mem_req_t          fetch_req,
   input  logic              fetch_gnt,
   input  mem_rsp_t          fetch_rsp,
   output instr_t            instr,
   output logic              instr_valid,
   output logic [addr_w-1:0] pc
);

   typedef enum logic [1:0] {
      f_idle,
      f_req,    // Request held until granted
      f_wait    // Granted, waiting for rvalid
   } f_state_t;

   f_state_t state;
   logic     need;   // First fetch after reset or run low

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= f_idle;
         pc          <= '0;
         need        <= 1'b1;
         instr_valid <= 1'b0;
      end else if (!run) begin   // Stopped core restarts at zero
         state       <= f_idle;
         pc          <= '0;
         need        <= 1'b1;
         instr_valid <= 1'b0;
      end else begin
         instr_valid <= 1'b0;
         case (state)
            f_idle: begin
               if (branch) begin   // Taken branch beats plain retire
                  pc    <= branch_target;
                  state <= f_req;
               end else if (next_instr) begin
                  pc    <= pc + 1'b1;
                  state <= f_req;
               end else if (need) begin
                  need  <= 1'b0;
                  state <= f_req;
               end
            end
            f_req: if (fetch_gnt) state <= f_wait;
            f_wait: begin
               if (fetch_rsp.rvalid) begin
                  instr_valid <= 1'b1;
                  state       <= f_idle;
               end
            end
            default: state <= f_idle;
         endcase
      end
   end

   // Instruction register, held for the whole execute
   always_ff @(posedge clk) begin
      if (state == f_wait && fetch_rsp.rvalid) instr <= fetch_rsp.rdata;
   end

   assign fetch_req = '{req: (state == f_req), we: 1'b0, addr: pc, wdata: '0};

endmodule

`default_nettype wire

// File: hw/exec_ctrl.sv
////////////////////
// Decode and execute for the loopers core
// Drives ALU and register file, issues loads and stores
////////////////////
`default_nettype none

module exec_ctrl
   import loopers_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              run,
   input  instr_t            instr,
   input  logic              instr_valid,
   input  logic [addr_w-1:0] pc,
   output logic              next_instr,
   output logic              branch,
   output logic [addr_w-1:0] branch_target,
   output reg_idx_t          rf_rd_a,
   output reg_idx_t          rf_rd_b,
   input  logic [data_w-1:0] rf_data_a,
   input  logic [data_w-1:0] rf_data_b,
   output logic              rf_we,
   output reg_idx_t          rf_wr_idx,
   output logic [data_w-1:0] rf_wr_data,
   output logic [data_w-1:0] alu_op1,
   output logic [data_w-1:0] alu_op2,
   output alu_mode_t         alu_mode,
   output logic              alu_en,
   output logic              alu_inv_rt,
   input  logic [data_w-1:0] alu_out,
   output mem_req_t          lsu_req,
   input  logic              lsu_gnt,
   input  mem_rsp_t          lsu_rsp,
   output logic              halted
);

   typedef enum logic [1:0] {
      e_idle,    // Waiting for instr_valid
      e_lsu,     // lsu_req held until granted
      e_load     // Load granted, waiting for data
   } e_state_t;

   e_state_t          state;
   opcode_t           opc;
   logic [addr_w-1:0] mem_addr;   // rs plus signed offset

   assign opc      = instr.r_fmt.opcode;
   assign mem_addr = rf_data_a[addr_w-1:0] + addr_w'(instr.m_fmt.off);

   // ALU fed straight from the register file
   assign alu_op1    = rf_data_a;
   assign alu_op2    = rf_data_b;
   assign alu_mode   = instr.r_fmt.mode;
   assign alu_inv_rt = (opc == op_alu_inv);

   ////////////////////
   // Decode
   ////////////////////
   always_comb begin
      rf_rd_a    = instr.r_fmt.rs;   // rs and rd share bit positions in every format
      rf_rd_b    = instr.r_fmt.rt;
      rf_we      = 1'b0;
      rf_wr_idx  = instr.r_fmt.rd;
      rf_wr_data = alu_out;
      alu_en     = 1'b0;
      case (opc)
         op_alu, op_alu_inv: begin   // Result written in the valid cycle
            alu_en = instr_valid;
            rf_we  = instr_valid;
         end
         op_ldi: begin
            rf_we      = instr_valid;
            rf_wr_data = data_w'(instr.i_fmt.imm);   // Sign extended
         end
         op_ld: begin
            rf_we      = (state == e_load) && lsu_rsp.rvalid;
            rf_wr_data = lsu_rsp.rdata;
         end
         op_st, op_bnz: rf_rd_b = instr.m_fmt.rd;   // Store data or tested register
         default: ;
      endcase
   end

   ////////////////////
   // Sequencing
   ////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state         <= e_idle;
         next_instr    <= 1'b0;
         branch        <= 1'b0;
         branch_target <= '0;
         lsu_req       <= '0;
         halted        <= 1'b0;
      end else if (!run) begin   // Run low also clears halted
         state         <= e_idle;
         next_instr    <= 1'b0;
         branch        <= 1'b0;
         branch_target <= '0;
         lsu_req       <= '0;
         halted        <= 1'b0;
      end else begin
         next_instr <= 1'b0;   // Pulses
         branch     <= 1'b0;
         case (state)
            e_idle: begin
               if (instr_valid) begin
                  case (opc)
                     op_ld, op_st: begin
                        lsu_req <= '{req: 1'b1, we: (opc == op_st), addr: mem_addr,
                                     wdata: rf_data_b};
                        state   <= e_lsu;
                     end
                     op_bnz: begin
                        next_instr <= 1'b1;
                        if (rf_data_b != '0) begin
                           branch        <= 1'b1;
                           branch_target <= pc + 1'b1 + addr_w'(instr.i_fmt.imm);
                        end
                     end
                     op_halt: halted <= 1'b1;   // No retire, fetch stays idle
                     default: next_instr <= 1'b1;   // ALU, ldi, unknown codes
                  endcase
               end
            end
            e_lsu: begin
               if (lsu_gnt) begin
                  lsu_req.req <= 1'b0;
                  if (lsu_req.we) begin   // Store done at grant
                     next_instr <= 1'b1;
                     state      <= e_idle;
                  end else begin
                     state <= e_load;
                  end
               end
            end
            e_load: begin
               if (lsu_rsp.rvalid) begin
                  next_instr <= 1'b1;
                  state      <= e_idle;
               end
            end
            default: state <= e_idle;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hw/loopers_top.sv
////////////////////
// Loopers core top level
// Host loads memory while run is low, halted ends a run
////////////////////
`default_nettype none

module loopers_top
   import loopers_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     run,
   input  mem_req_t host_req,
   output mem_rsp_t host_rsp,
   output logic     halted
);

   // Memory side
   mem_req_t          fetch_req;
   mem_req_t          lsu_req;
   mem_req_t          mem_req;
   mem_rsp_t          fetch_rsp;
   mem_rsp_t          lsu_rsp;
   logic              fetch_gnt;
   logic              lsu_gnt;
   logic [data_w-1:0] mem_rdata;

   // Fetch to execute
   instr_t            instr;
   logic              instr_valid;
   logic [addr_w-1:0] pc;
   logic              next_instr;
   logic              branch;
   logic [addr_w-1:0] branch_target;

   // Register file and ALU
   reg_idx_t          rf_rd_a;
   reg_idx_t          rf_rd_b;
   logic [data_w-1:0] rf_data_a;
   logic [data_w-1:0] rf_data_b;
   logic              rf_we;
   reg_idx_t          rf_wr_idx;
   logic [data_w-1:0] rf_wr_data;
   logic [data_w-1:0] alu_op1;
   logic [data_w-1:0] alu_op2;
   alu_mode_t         alu_mode;
   logic              alu_en;
   logic              alu_inv_rt;
   logic [data_w-1:0] alu_out;

   ////////////////////
   // Memory path
   ////////////////////
   mem_arbiter i_arb (
      .clk, .rst_n, .host_req, .lsu_req, .fetch_req, .lsu_gnt, .fetch_gnt,
      .host_rsp, .lsu_rsp, .fetch_rsp, .mem_req, .mem_rdata
   );

   unified_mem i_mem (
      .clk,
      .mem_req,
      .rdata   (mem_rdata)
   );

   ////////////////////
   // Core
   ////////////////////
   fetch_unit i_fetch (
      .clk, .rst_n, .run, .next_instr, .branch, .branch_target,
      .fetch_req, .fetch_gnt, .fetch_rsp, .instr, .instr_valid, .pc
   );

   exec_ctrl i_exec (
      .clk, .rst_n, .run, .instr, .instr_valid, .pc,
      .next_instr, .branch, .branch_target,
      .rf_rd_a, .rf_rd_b, .rf_data_a, .rf_data_b, .rf_we, .rf_wr_idx, .rf_wr_data,
      .alu_op1, .alu_op2, .alu_mode, .alu_en, .alu_inv_rt, .alu_out,
      .lsu_req, .lsu_gnt, .lsu_rsp, .halted
   );

   reg_file i_rf (
      .clk,
      .rst_n,
      .rd_a    (rf_rd_a),
      .rd_b    (rf_rd_b),
      .data_a  (rf_data_a),
      .data_b  (rf_data_b),
      .we      (rf_we),
      .wr_idx  (rf_wr_idx),
      .wr_data (rf_wr_data)
   );

   alu i_alu (
      .alu_op1, .alu_op2, .alu_mode, .alu_en, .alu_inv_rt, .alu_out
   );

endmodule

`default_nettype wire

// File: verif/loopers_tb.sv
////////////////////
// Testbench for the loopers core
// Host port loads operands and programs, raises run, waits for halted
// and reads results back. ALU rows come from a table, plus host,
// load/store and branch loop tests
////////////////////
`default_nettype none

module loopers_tb
   import loopers_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int n_dir       = 17;   // Directed ALU rows
   localparam int n_rand      = 8;
   localparam int n_extra     = 3;    // Host, load/store and loop tests
   localparam int row_cycles  = 64;   // Writes, program, run and readback
   localparam int cycle_limit = (n_dir + n_rand + n_extra) * row_cycles * 4;

   localparam logic [addr_w-1:0] alu_base  = 8'h80;
   localparam logic [addr_w-1:0] loop_base = 8'hc0;
   localparam int                loop_n    = 5;
   localparam int                neg_imm   = -100;

   typedef struct packed {
      logic [data_w-1:0] a;
      logic [data_w-1:0] b;
      opcode_t           opc;   // Plain or inverted ALU op
      alu_mode_t         mode;
      logic [data_w-1:0] exp;
   } alu_row_t;

   logic     clk;
   logic     rst_n;
   logic     run;
   mem_req_t host_req;
   mem_rsp_t host_rsp;
   logic     halted;

   alu_row_t rows [$];
   int       n_mismatch;
   int       n_fail;
   int       cycle_cnt = 0;

   loopers_top i_dut (.clk, .rst_n, .run, .host_req, .host_rsp, .halted);

   always #50 clk = ~clk;   // 100 ns period

   // Run limit scaled from the test count
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("timeout: simulation stopped after %0d cycles", cycle_cnt);
         $display("tests failed");
         $finish;
      end
   end

   ////////////////////
   // Program builder
   ////////////////////
   function automatic instr_t enc_alu(opcode_t opc, reg_idx_t rd, reg_idx_t rs,
                                      reg_idx_t rt, alu_mode_t mode);
      instr_t w;
      w.r_fmt = '{opcode: opc, rd: rd, rs: rs, rt: rt, mode: mode};
      return w;
   endfunction

   function automatic instr_t enc_imm(opcode_t opc, reg_idx_t rd, int imm);
      instr_t w;
      w.i_fmt = '{opcode: opc, rd: rd, imm: 9'(imm)};
      return w;
   endfunction

   function automatic instr_t enc_mem(opcode_t opc, reg_idx_t rd, reg_idx_t rs, int off);
      instr_t w;
      w.m_fmt = '{opcode: opc, rd: rd, rs: rs, off: 6'(off)};
      return w;
   endfunction

   // Expected ALU result
   function automatic logic [data_w-1:0] alu_ref(logic [data_w-1:0] a, logic [data_w-1:0] b,
                                                  logic inv, alu_mode_t mode);
      logic [data_w-1:0]   bx;
      logic [2*data_w-1:0] ext;   // op1 with its sign copied into the top half
      bx  = inv ? ~b : b;
      ext = {{data_w{a[data_w-1]}}, a} >> b[3:0];   // Count from raw op2
      case (mode)
         add, add_alt: return a + bx;
         sub:          return a + bx + 16'd1;
         and_op:       return a & bx;
         or_op:        return a | bx;
         xor_op:       return a ^ bx;
         not_op:       return ~a;
         sra:          return ext[data_w-1:0];
         default:      return '0;
      endcase
   endfunction

   ////////////////////
   // Compare tasks
   ////////////////////
   task automatic check_word(owner_t src, string what, logic [data_w-1:0] exp,
                             logic [data_w-1:0] act);
      if (act !== exp) begin
         n_mismatch++;
         $display("mismatch at %0d ns: %s %s expected %h got %h",
                  $time, src.name(), what, exp, act);
      end
   endtask

   task automatic check_halt(string what, logic exp);
      if (halted !== exp) begin
         n_mismatch++;
         $display("mismatch at %0d ns: halted in %s expected %b got %b",
                  $time, what, exp, halted);
      end
   endtask

   ////////////////////
   // Host port and run control
   ////////////////////
   task automatic host_write(logic [addr_w-1:0] addr, logic [data_w-1:0] data);
      @(posedge clk);
      host_req <= '{req: 1'b1, we: 1'b1, addr: addr, wdata: data};
   endtask

   task automatic host_idle();
      @(posedge clk);
      host_req <= '0;
   endtask

   task automatic host_read(logic [addr_w-1:0] addr, output logic [data_w-1:0] data);
      @(posedge clk);
      host_req <= '{req: 1'b1, we: 1'b0, addr: addr, wdata: '0};
      @(posedge clk);
      host_req <= '0;
      @(negedge clk);   // One cycle after the request cycle
      data = host_rsp.rdata;
      if (host_rsp.rvalid !== 1'b1) begin
         n_fail++;
         $display("host read of address %h returned no data at %0d ns", addr, $time);
      end
   endtask

   task automatic run_program(string what);
      @(posedge clk);
      run <= 1'b1;
      while (halted !== 1'b1) @(negedge clk);   // Global limit catches a hang
      repeat (3) begin   // Must hold while run stays high
         @(negedge clk);
         check_halt(what, 1'b1);
      end
      @(posedge clk);
      run <= 1'b0;
      repeat (2) @(negedge clk);
      check_halt(what, 1'b0);
   endtask

   ////////////////////
   // Tests
   ////////////////////
   task automatic host_test();
      logic [data_w-1:0] words [8];
      logic [data_w-1:0] got;
      for (int i = 0; i < 8; i++) begin
         words[i] = 16'($urandom);
         host_write(8'h40 + 8'(i), words[i]);
      end
      host_idle();
      for (int i = 0; i < 8; i++) begin
         host_read(8'h40 + 8'(i), got);
         check_word(own_host, $sformatf("host word %0d", i), words[i], got);
         check_halt("host access", 1'b0);   // run still low
      end
   endtask

   task automatic run_alu_row(int idx, alu_row_t r);
      logic [data_w-1:0] sentinel;
      logic [data_w-1:0] got;
      sentinel = 16'($urandom);
      host_write(alu_base, r.a);
      host_write(alu_base + 8'd1, r.b);
      host_write(alu_base + 8'd2, ~r.exp);     // Old value differs from the result
      host_write(alu_base + 8'd3, sentinel);   // Next to the result word
      host_write(8'd0, enc_imm(op_ldi, 3'd7, int'(alu_base)));
      host_write(8'd1, enc_mem(op_ld, 3'd1, 3'd7, 0));
      host_write(8'd2, enc_mem(op_ld, 3'd2, 3'd7, 1));
      host_write(8'd3, enc_alu(r.opc, 3'd3, 3'd1, 3'd2, r.mode));
      host_write(8'd4, enc_mem(op_st, 3'd3, 3'd7, 2));
      host_write(8'd5, enc_imm(op_halt, 3'd0, 0));
      host_idle();
      run_program($sformatf("alu row %0d", idx));
      host_read(alu_base + 8'd2, got);
      check_word(own_lsu, $sformatf("row %0d result", idx), r.exp, got);
      host_read(alu_base + 8'd3, got);
      check_word(own_host, $sformatf("row %0d neighbor", idx), sentinel, got);
   endtask

   // Negative offsets around base 0xa0
   task automatic ldst_test();
      logic [data_w-1:0] src_word;
      logic [data_w-1:0] fill [3];
      logic [data_w-1:0] got;
      src_word = 16'($urandom);
      for (int i = 0; i < 3; i++) begin
         fill[i] = 16'($urandom);
      end
      host_write(8'h9b, src_word);   // Load source at base - 5
      host_write(8'h9c, fill[0]);
      host_write(8'h9d, 16'h0000);   // Store target at base - 3
      host_write(8'h9e, fill[1]);
      host_write(8'ha1, fill[2]);
      host_write(8'ha2, 16'h0000);   // Copy target at base + 2
      host_write(8'd0, enc_imm(op_ldi, 3'd7, 160));
      host_write(8'd1, enc_imm(op_ldi, 3'd4, 165));
      host_write(8'd2, enc_mem(op_st, 3'd4, 3'd7, -3));
      host_write(8'd3, enc_mem(op_ld, 3'd5, 3'd7, -5));
      host_write(8'd4, enc_mem(op_st, 3'd5, 3'd7, 2));
      host_write(8'd5, enc_imm(op_halt, 3'd0, 0));
      host_idle();
      run_program("load/store");
      host_read(8'h9d, got);
      check_word(own_lsu, "store at offset -3", 16'h00a5, got);
      host_read(8'ha2, got);
      check_word(own_lsu, "load at offset -5", src_word, got);
      host_read(8'h9c, got);
      check_word(own_host, "word 9c", fill[0], got);
      host_read(8'h9e, got);
      check_word(own_host, "word 9e", fill[1], got);
      host_read(8'ha1, got);
      check_word(own_host, "word a1", fill[2], got);
   endtask

   // Countdown with bnz, counter must end at N
   task automatic loop_test();
      logic [data_w-1:0] sentinel;
      logic [data_w-1:0] got;
      sentinel = 16'($urandom);
      host_write(loop_base, 16'(loop_n));
      host_write(loop_base + 8'd1, 16'h0000);
      host_write(loop_base + 8'd2, 16'h0000);
      host_write(loop_base + 8'd3, sentinel);
      host_write(8'd0, enc_imm(op_ldi, 3'd7, int'(loop_base)));
      host_write(8'd1, enc_mem(op_ld, 3'd1, 3'd7, 0));           // r1 = N
      host_write(8'd2, enc_imm(op_ldi, 3'd2, 1));
      host_write(8'd3, enc_imm(op_ldi, 3'd5, 0));                // Counter
      host_write(8'd4, enc_alu(op_alu_inv, 3'd1, 3'd1, 3'd2, sub));
      host_write(8'd5, enc_alu(op_alu, 3'd5, 3'd5, 3'd2, add));
      host_write(8'd6, enc_imm(op_bnz, 3'd1, -3));               // Back to 4
      host_write(8'd7, enc_mem(op_st, 3'd5, 3'd7, 1));
      host_write(8'd8, enc_imm(op_ldi, 3'd6, neg_imm));
      host_write(8'd9, enc_mem(op_st, 3'd6, 3'd7, 2));
      host_write(8'd10, enc_imm(op_halt, 3'd0, 0));
      host_idle();
      run_program("bnz loop");
      host_read(loop_base + 8'd1, got);
      check_word(own_lsu, "loop counter", 16'(loop_n), got);
      host_read(loop_base + 8'd2, got);
      check_word(own_lsu, "negative ldi", 16'(neg_imm), got);
      host_read(loop_base + 8'd3, got);
      check_word(own_host, "loop neighbor", sentinel, got);
   endtask

   ////////////////////
   // Main sequence
   ////////////////////
   initial begin
      alu_row_t r;
      clk        = 1'b0;
      rst_n      = 1'b0;
      run        = 1'b0;
      host_req   = '0;
      n_mismatch = 0;
      n_fail     = 0;
      void'($urandom(32'hbbc4ac03));

      // a, b, opcode, mode, expected
      rows.push_back('{16'h1234, 16'h0101, op_alu,     add,     16'h1335});
      rows.push_back('{16'hffff, 16'h0002, op_alu,     add_alt, 16'h0001});
      rows.push_back('{16'h0010, 16'h0005, op_alu,     sub,     16'h0016});
      rows.push_back('{16'h0010, 16'h0005, op_alu_inv, sub,     16'h000b});
      rows.push_back('{16'h0003, 16'h0005, op_alu_inv, sub,     16'hfffe});
      rows.push_back('{16'h0100, 16'h0001, op_alu_inv, add,     16'h00fe});
      rows.push_back('{16'hf0f0, 16'h3c3c, op_alu,     and_op,  16'h3030});
      rows.push_back('{16'hffff, 16'h00ff, op_alu_inv, and_op,  16'hff00});
      rows.push_back('{16'hf0f0, 16'h0c0c, op_alu,     or_op,   16'hfcfc});
      rows.push_back('{16'h0f00, 16'hffff, op_alu_inv, or_op,   16'h0f00});
      rows.push_back('{16'haaaa, 16'h0ff0, op_alu,     xor_op,  16'ha55a});
      rows.push_back('{16'h1234, 16'h0000, op_alu_inv, xor_op,  16'hedcb});
      rows.push_back('{16'h1234, 16'h5555, op_alu,     not_op,  16'hedcb});
      rows.push_back('{16'h8001, 16'hfff0, op_alu,     sra,     16'h8001});   // Shift 0
      rows.push_back('{16'h4321, 16'h0010, op_alu,     sra,     16'h4321});   // Shift 0
      rows.push_back('{16'h8001, 16'h000f, op_alu,     sra,     16'hffff});
      rows.push_back('{16'h7fff, 16'h000f, op_alu,     sra,     16'h0000});
      for (int i = 0; i < n_rand; i++) begin
         r.a    = 16'($urandom);
         r.b    = 16'($urandom);
         r.opc  = ($urandom % 2 != 0) ? op_alu_inv : op_alu;
         r.mode = alu_mode_t'(3'($urandom));
         r.exp  = alu_ref(r.a, r.b, r.opc == op_alu_inv, r.mode);
         rows.push_back(r);
      end

      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_halt("reset", 1'b0);

      host_test();
      for (int i = 0; i < rows.size(); i++) begin
         run_alu_row(i, rows[i]);
      end
      ldst_test();
      loop_test();

      $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_fail);
      if (n_mismatch == 0 && n_fail == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
hw/loopers_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/unified_mem.sv
hw/mem_arbiter.sv
hw/fetch_unit.sv
hw/exec_ctrl.sv
hw/loopers_top.sv
verif/loopers_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile the loopers core and its testbench with Verilator, then run it.
# The run passes only if the simulation prints the pass line.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
   -f vlog.f --top-module loopers_tb -o loopers_sim

out=$(./obj_dir/loopers_sim)
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
   exit 0
fi
exit 1
